// ==== include/rv_consts.svh ====
// RV32I widths, register count and encodings shared by the package, the core and its testbench
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath and address widths
`define RV_XLEN      32
`define RV_RADDR_W   5
`define RV_NREGS     32

// Word address on both memory ports, PC with its two low bits dropped
`define RV_IADDR_W   30

// Sequential fetch step in bytes
`define RV_PC_STEP   32'd4

// addi x0, x0, 0
// Loaded into fetch/decode on reset and on a taken-branch flush
`define RV_NOP_INST  32'h0000_0013

// Instruction field positions
`define RV_OPC_HI    6
`define RV_OPC_LO    2
`define RV_RD_HI     11
`define RV_RD_LO     7
`define RV_RS1_HI    19
`define RV_RS1_LO    15
`define RV_RS2_HI    24
`define RV_RS2_LO    20

`endif

// ==== hdl/rv_pkg.sv ====
// Opcode and ALU-operation enums plus the operand forwarding helper, imported by the RTL modules
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

	// Major opcode, instruction bits [6:2]
	typedef enum logic [4:0] {
		LOAD   = 5'b00000,
		OP_IMM = 5'b00100,
		STORE  = 5'b01000,
		OP     = 5'b01100,
		BRANCH = 5'b11000
	} opcode_t;

	// funct7[5] followed by funct3
	typedef enum logic [3:0] {
		ADD = 4'b0000,
		SLL = 4'b0001,
		SLT = 4'b0010,
		XOR = 4'b0100,
		SRL = 4'b0101,
		OR  = 4'b0110,
		AND = 4'b0111,
		SUB = 4'b1000,
		SRA = 4'b1101
	} aluOp_t;

	// Newest producer wins, memory stage before write-back, x0 never forwarded
	function automatic logic [`RV_XLEN-1:0] fwdOperand(
		input logic [`RV_RADDR_W-1:0] rs,
		input logic [`RV_XLEN-1:0]    regVal,
		input logic [`RV_RADDR_W-1:0] meRd,
		input logic                   meRegWrite,
		input logic [`RV_XLEN-1:0]    meVal,
		input logic [`RV_RADDR_W-1:0] wbRd,
		input logic                   wbRegWrite,
		input logic [`RV_XLEN-1:0]    wbVal
	);
		if (meRegWrite && (meRd == rs) && (rs != '0)) begin
			return meVal;
		end else if (wbRegWrite && (wbRd == rs) && (rs != '0)) begin
			return wbVal;
		end
		return regVal;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/rvAlu.sv ====
// Execute-stage integer ALU, one RV32I operation per cycle, purely combinational
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rvAlu (
	input  logic [`RV_XLEN-1:0] inA,
	input  logic [`RV_XLEN-1:0] inB,
	input  rv_pkg::aluOp_t      op,
	output logic [`RV_XLEN-1:0] result
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic       lessThan;

	assign shamt    = inB[4:0];  // RV32I shifts use the low five bits
	assign lessThan = $signed(inA) < $signed(inB);

	always_comb begin
		case (op)
			ADD: result = $signed(inA) + $signed(inB);
			SUB: result = $signed(inA) - $signed(inB);
			SLL: result = inA << shamt;
			SLT: result = {{(`RV_XLEN-1){1'b0}}, lessThan};
			XOR: result = inA ^ inB;
			SRL: result = inA >> shamt;
			SRA: result = $signed(inA) >>> shamt;  // Sign bit fills from the left
			OR:  result = inA | inB;
			AND: result = inA & inB;
			default: begin
				// sltu and other unsupported funct3 values
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/rvDecoder.sv ====
// Decode-stage control unit, turns the fetched word into strobes, an ALU operation and the immediate
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rvDecoder (
	input  logic [`RV_XLEN-1:0] inst,
	output logic                memRead,
	output logic                memWrite,
	output logic                memToReg,
	output logic                aluSrc,
	output logic                regWrite,
	output logic                isBeq,
	output logic                isBne,
	output rv_pkg::aluOp_t      aluOp,
	output logic [`RV_XLEN-1:0] imm
);
	import rv_pkg::*;

	opcode_t            opcode;
	logic [2:0]         funct3;
	logic [`RV_XLEN-1:0] immI;
	logic [`RV_XLEN-1:0] immShamt;
	logic [`RV_XLEN-1:0] immS;
	logic [`RV_XLEN-1:0] immB;

	assign opcode = opcode_t'(inst[`RV_OPC_HI:`RV_OPC_LO]);
	assign funct3 = inst[14:12];

	// Immediate formats
	assign immI     = {{20{inst[31]}}, inst[31:20]};
	assign immShamt = {27'b0, inst[24:20]};
	assign immS     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

	always_comb begin
		memRead  = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluSrc   = 1'b0;
		regWrite = 1'b0;
		isBeq    = 1'b0;
		isBne    = 1'b0;
		aluOp    = ADD;  // Address math and unknown opcodes
		imm      = '0;
		case (opcode)
			OP: begin
				regWrite = 1'b1;
				aluOp    = aluOp_t'({inst[30], funct3});
			end
			OP_IMM: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				// Only srai carries funct7[5], addi and friends use it as an immediate bit
				if (funct3 == 3'b101) begin
					aluOp = aluOp_t'({inst[30], funct3});
				end else begin
					aluOp = aluOp_t'({1'b0, funct3});
				end
				imm = (funct3 == 3'b001 || funct3 == 3'b101) ? immShamt : immI;
			end
			LOAD: begin
				memRead  = 1'b1;
				memToReg = 1'b1;
				aluSrc   = 1'b1;
				regWrite = 1'b1;
				imm      = immI;
			end
			STORE: begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
				imm      = immS;
			end
			BRANCH: begin
				isBeq = (funct3 == 3'b000);
				isBne = (funct3 == 3'b001);
				imm   = immB;  // PC relative, added in the hazard unit
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/rvRegFile.sv ====
// Integer register file with x0 tied to zero and same-cycle write-to-read bypass
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rvRegFile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`RV_RADDR_W-1:0] rs1Addr,
	input  logic [`RV_RADDR_W-1:0] rs2Addr,
	input  logic [`RV_RADDR_W-1:0] wrAddr,
	input  logic                   wrEn,
	input  logic [`RV_XLEN-1:0]    wrData,
	output logic [`RV_XLEN-1:0]    rs1Data,
	output logic [`RV_XLEN-1:0]    rs2Data
);

	logic [`RV_XLEN-1:0] regs [`RV_NREGS];
	logic                wrLive;

	assign wrLive = wrEn && (wrAddr != '0);

	// Write-back value visible to decode in the cycle it is written
	assign rs1Data = (wrLive && (wrAddr == rs1Addr)) ? wrData : regs[rs1Addr];
	assign rs2Data = (wrLive && (wrAddr == rs2Addr)) ? wrData : regs[rs2Addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;  // Entry 0 stays at its reset value
		end
	end

	// x0 reads zero whatever was written to it before
	assert property (@(posedge clk) disable iff (!rst_n)
		((rs1Addr == '0) -> (rs1Data == '0)) && ((rs2Addr == '0) -> (rs2Data == '0)));

endmodule

`default_nettype wire

// ==== hdl/rvHazardUnit.sv ====
// Decode-stage branch resolution with its own forwarding, plus load-use and branch-operand stalls
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rvHazardUnit (
	input  logic                   isBeq,
	input  logic                   isBne,
	input  logic [`RV_RADDR_W-1:0] rs1Addr,
	input  logic [`RV_RADDR_W-1:0] rs2Addr,
	input  logic [`RV_XLEN-1:0]    rs1Data,
	input  logic [`RV_XLEN-1:0]    rs2Data,
	input  logic [`RV_XLEN-1:0]    pcId,
	input  logic [`RV_XLEN-1:0]    imm,
	input  logic [`RV_RADDR_W-1:0] exRd,
	input  logic                   exMemRead,
	input  logic                   exRegWrite,
	input  logic [`RV_RADDR_W-1:0] meRd,
	input  logic                   meRegWrite,
	input  logic [`RV_XLEN-1:0]    meData,
	input  logic [`RV_RADDR_W-1:0] wbRd,
	input  logic                   wbRegWrite,
	input  logic [`RV_XLEN-1:0]    wbData,
	output logic                   branchTaken,
	output logic [`RV_XLEN-1:0]    branchTarget,
	output logic                   hazardStall,
	output logic                   flushFetch
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0] opA;
	logic [`RV_XLEN-1:0] opB;
	logic                opEqual;
	logic                isBranch;
	logic                exHitsSrc;
	logic                loadUse;
	logic                branchOnEx;

	// Branch operands, newest value first
	assign opA = fwdOperand(rs1Addr, rs1Data, meRd, meRegWrite, meData,
		wbRd, wbRegWrite, wbData);
	assign opB = fwdOperand(rs2Addr, rs2Data, meRd, meRegWrite, meData,
		wbRd, wbRegWrite, wbData);

	assign opEqual      = (opA == opB);
	assign isBranch     = isBeq | isBne;
	assign branchTaken  = (isBeq & opEqual) | (isBne & ~opEqual);
	assign branchTarget = pcId + imm;

	// ================================================================
	// Stall detection against the instruction in execute
	// ================================================================
	assign exHitsSrc = (exRd != '0) && ((exRd == rs1Addr) || (exRd == rs2Addr));

	assign loadUse    = exMemRead & exHitsSrc;                // Data not ready until memory
	assign branchOnEx = isBranch & exRegWrite & exHitsSrc;    // Result still in the ALU

	assign hazardStall = loadUse | branchOnEx;

	// A stalled branch compares stale operands, redirect only once it goes
	assign flushFetch = branchTaken & ~hazardStall;

endmodule

`default_nettype wire

// ==== hdl/rvCore.sv ====
// Five-stage RV32I pipeline top, connect word-addressed instruction and data memories with stalls
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rvCore (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic [`RV_IADDR_W-1:0] iAddr,
	input  logic [`RV_XLEN-1:0]    iRdata,
	input  logic                   iStall,
	output logic                   dRead,
	output logic                   dWrite,
	output logic [`RV_IADDR_W-1:0] dAddr,
	output logic [`RV_XLEN-1:0]    dWdata,
	input  logic [`RV_XLEN-1:0]    dRdata,
	input  logic                   dStall
);
	import rv_pkg::*;

	logic freeze;  // Either memory holding the whole pipe
	logic hazardStall, flushFetch, branchTaken;
	logic [`RV_XLEN-1:0] branchTarget;

	// Fetch and fetch/decode
	logic [`RV_XLEN-1:0] pc, pcNext;
	logic [`RV_XLEN-1:0] idPc, idInst;

	// Decode
	logic [`RV_RADDR_W-1:0] idRs1, idRs2, idRd;
	logic [`RV_XLEN-1:0]    idRs1Data, idRs2Data, idImm;
	logic idMemRead, idMemWrite, idMemToReg, idAluSrc, idRegWrite, idBeq, idBne;
	aluOp_t idAluOp;

	// Decode/execute
	logic [`RV_RADDR_W-1:0] exRs1, exRs2, exRd;
	logic [`RV_XLEN-1:0]    exRs1Data, exRs2Data, exImm;
	logic exMemRead, exMemWrite, exMemToReg, exAluSrc, exRegWrite;
	aluOp_t exAluOp;
	logic [`RV_XLEN-1:0] aluA, fwdB, aluB, exResult;

	// Execute/memory and memory/write-back
	logic [`RV_RADDR_W-1:0] meRd, wbRd;
	logic [`RV_XLEN-1:0]    meAlu, meWdata, meResult;
	logic meMemRead, meMemWrite, meMemToReg, meRegWrite;
	logic [`RV_XLEN-1:0]    wbAlu, wbLoad, wbData;
	logic wbMemToReg, wbRegWrite;

	assign freeze = iStall | dStall;

	// ============================================================
	// Fetch
	// ============================================================
	assign iAddr  = pc[`RV_XLEN-1:2];
	assign pcNext = pc + `RV_PC_STEP;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!freeze && !hazardStall) begin
			pc <= branchTaken ? branchTarget : pcNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idInst <= `RV_NOP_INST;
		end else if (!freeze && !hazardStall) begin
			idInst <= flushFetch ? `RV_NOP_INST : iRdata;  // Squash the wrong-path word
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze && !hazardStall) begin
			idPc <= pc;
		end
	end

	// ============================================================
	// Decode
	// ============================================================
	assign idRs1 = idInst[`RV_RS1_HI:`RV_RS1_LO];
	assign idRs2 = idInst[`RV_RS2_HI:`RV_RS2_LO];
	assign idRd  = idInst[`RV_RD_HI:`RV_RD_LO];

	rvDecoder uDecoder (
		.inst(idInst), .memRead(idMemRead), .memWrite(idMemWrite), .memToReg(idMemToReg),
		.aluSrc(idAluSrc), .regWrite(idRegWrite), .isBeq(idBeq), .isBne(idBne),
		.aluOp(idAluOp), .imm(idImm)
	);

	// Held write-back must not land twice
	rvRegFile uRegFile (
		.clk(clk), .rst_n(rst_n), .rs1Addr(idRs1), .rs2Addr(idRs2), .wrAddr(wbRd),
		.wrEn(wbRegWrite & ~freeze), .wrData(wbData), .rs1Data(idRs1Data), .rs2Data(idRs2Data)
	);

	rvHazardUnit uHazard (
		.isBeq(idBeq), .isBne(idBne), .rs1Addr(idRs1), .rs2Addr(idRs2),
		.rs1Data(idRs1Data), .rs2Data(idRs2Data), .pcId(idPc), .imm(idImm),
		.exRd(exRd), .exMemRead(exMemRead), .exRegWrite(exRegWrite),
		.meRd(meRd), .meRegWrite(meRegWrite), .meData(meResult),
		.wbRd(wbRd), .wbRegWrite(wbRegWrite), .wbData(wbData),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.hazardStall(hazardStall), .flushFetch(flushFetch)
	);

	// Bubble on a hazard, hold on freeze
	always_ff @(posedge clk) begin
		if (!rst_n || (!freeze && hazardStall)) begin
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exAluSrc   <= 1'b0;
			exRegWrite <= 1'b0;
			exAluOp    <= ADD;
		end else if (!freeze) begin
			exMemRead  <= idMemRead;
			exMemWrite <= idMemWrite;
			exMemToReg <= idMemToReg;
			exAluSrc   <= idAluSrc;
			exRegWrite <= idRegWrite;
			exAluOp    <= idAluOp;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			exRs1     <= idRs1;
			exRs2     <= idRs2;
			exRd      <= idRd;
			exRs1Data <= idRs1Data;
			exRs2Data <= idRs2Data;
			exImm     <= idImm;
		end
	end

	// ============================================================
	// Execute
	// ============================================================
	assign aluA = fwdOperand(exRs1, exRs1Data, meRd, meRegWrite, meResult,
		wbRd, wbRegWrite, wbData);
	assign fwdB = fwdOperand(exRs2, exRs2Data, meRd, meRegWrite, meResult,
		wbRd, wbRegWrite, wbData);
	assign aluB = exAluSrc ? exImm : fwdB;

	rvAlu uAlu (.inA(aluA), .inB(aluB), .op(exAluOp), .result(exResult));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			meMemRead  <= 1'b0;
			meMemWrite <= 1'b0;
			meMemToReg <= 1'b0;
			meRegWrite <= 1'b0;
		end else if (!freeze) begin
			meMemRead  <= exMemRead;
			meMemWrite <= exMemWrite;
			meMemToReg <= exMemToReg;
			meRegWrite <= exRegWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			meRd    <= exRd;
			meAlu   <= exResult;
			meWdata <= fwdB;  // Store data after forwarding
		end
	end

	// ============================================================
	// Memory and write-back
	// ============================================================
	assign dRead  = meMemRead;
	assign dWrite = meMemWrite;
	assign dAddr  = meAlu[`RV_XLEN-1:2];
	assign dWdata = meWdata;

	// Load data is same-cycle, so a branch waiting on a load can take it here
	assign meResult = meMemToReg ? dRdata : meAlu;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbMemToReg <= 1'b0;
			wbRegWrite <= 1'b0;
		end else if (!freeze) begin
			wbMemToReg <= meMemToReg;
			wbRegWrite <= meRegWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			wbRd   <= meRd;
			wbAlu  <= meAlu;
			wbLoad <= dRdata;
		end
	end

	assign wbData = wbMemToReg ? wbLoad : wbAlu;

	// Only one data access per cycle
	assert property (@(posedge clk) disable iff (!rst_n) !(dRead && dWrite));

	// A stalled access keeps its address and strobe until accepted
	assert property (@(posedge clk) disable iff (!rst_n)
		(dStall && (dRead || dWrite)) |=> ($stable(dAddr) && $stable(dRead) && $stable(dWrite)));

endmodule

`default_nettype wire

// ==== sim/tb_rvCore.sv ====
// Self-checking testbench for the five-stage core that runs small programs and compares the store stream
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_rvCore;

	// Longest run is about 65 instructions and loop passes or near 150 cycles unstalled
	// Random stalls roughly double that, so 7 runs with reset and drain stay far below
	localparam int MAX_CYCLES = 4000;
	localparam int DRAIN_CYCLES = 20;  // Quiet time that catches stray stores
	localparam logic [31:0] SELF_LOOP = 32'h0000_0063;  // beq x0, x0, 0

	logic                   clk;
	logic                   rst_n;
	logic [`RV_IADDR_W-1:0] iAddr;
	logic [`RV_XLEN-1:0]    iRdata;
	logic                   iStall;
	logic                   dRead;
	logic                   dWrite;
	logic [`RV_IADDR_W-1:0] dAddr;
	logic [`RV_XLEN-1:0]    dWdata;
	logic [`RV_XLEN-1:0]    dRdata;
	logic                   dStall;

	logic [`RV_XLEN-1:0] imem [256];
	logic [`RV_XLEN-1:0] dmem [256];
	logic [31:0]         expAddr [256];  // Word address of each expected store
	logic [31:0]         expData [256];
	logic [31:0]         rngState;
	int                  progLen;
	int                  expCount;
	int                  seen;
	int                  cycles;
	int                  errorCount;
	int                  checkCount;
	bit                  randomStalls;
	string               testName;

	assign iRdata = imem[iAddr[7:0]];
	assign dRdata = dRead ? dmem[dAddr[7:0]] : '0;  // Read data only while dRead is high

	rvCore u_dut (
		.clk(clk), .rst_n(rst_n), .iAddr(iAddr), .iRdata(iRdata), .iStall(iStall),
		.dRead(dRead), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata),
		.dRdata(dRdata), .dStall(dStall)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ============================================================
	// Helpers
	// ============================================================
	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Every bit of the word index shows up in the reset contents
	function automatic logic [31:0] fillWord(input logic [7:0] idx);
		return {idx, ~idx, idx ^ 8'h5A, 8'hC3 + idx};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[progLen[7:0]] = word;
		progLen++;
	endtask

	function automatic int here();
		return progLen * 4;  // Byte address of the next instruction
	endfunction

	task automatic emitR(input int f7, input int f3, input int rd, input int rs1, input int rs2);
		emit({f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011});
	endtask

	task automatic emitI(input int f3, input int rd, input int rs1, input int imm);
		emit({imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011});
	endtask

	task automatic emitLw(input int rd, input int rs1, input int imm);
		emit({imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011});
	endtask

	task automatic emitSw(input int rs2, input int rs1, input int imm);
		emit({imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011});
	endtask

	task automatic emitBranch(input int f3, input int rs1, input int rs2, input int off);
		emit({off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011});
	endtask

	// Dump x0..x31 above the data area, then park
	task automatic storeAllRegs();
		for (int r = 0; r < `RV_NREGS; r++) begin
			emitSw(r, 0, 256 + 4 * r);
		end
		emit(SELF_LOOP);
	endtask

	// ISA-level meaning of funct3 where alt picks sub and sra
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) r = $signed(a) >>> b[4:0];
				else r = a >> b[4:0];
			end
			3'd6: r = a | b;
			3'd7: r = a & b;
			default: r = 32'd0;
		endcase
		return r;
	endfunction

	// Runs the loaded program one instruction at a time and lists its stores
	function automatic int runReference();
		logic [31:0] regs [`RV_NREGS];
		logic [31:0] mem [256];
		logic [31:0] pc, inst, a, b, addr, immB;
		logic [2:0]  f3;
		logic        taken;
		int          n, steps;
		bit          done;
		n = 0;
		steps = 0;
		done = 0;
		pc = 32'd0;
		for (int i = 0; i < `RV_NREGS; i++) regs[i[4:0]] = 32'd0;
		for (int i = 0; i < 256; i++) mem[i[7:0]] = fillWord(i[7:0]);
		while (!done && steps < 2000) begin
			inst = imem[pc[9:2]];
			f3 = inst[14:12];
			a = regs[inst[19:15]];
			b = regs[inst[24:20]];
			steps++;
			case (inst[6:0])
				7'b0110011: regs[inst[11:7]] = aluRef(f3, inst[30], a, b);
				7'b0010011: regs[inst[11:7]] = aluRef(f3, inst[30] && (f3 == 3'd5), a,
					{{20{inst[31]}}, inst[31:20]});
				7'b0000011: begin
					addr = a + {{20{inst[31]}}, inst[31:20]};
					regs[inst[11:7]] = mem[addr[9:2]];
				end
				7'b0100011: begin
					addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
					mem[addr[9:2]] = b;
					expAddr[n[7:0]] = {2'b00, addr[31:2]};
					expData[n[7:0]] = b;
					n++;
				end
				default: ;
			endcase
			regs[0] = 32'd0;  // x0 never keeps a write
			if (inst[6:0] == 7'b1100011) begin
				immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
				taken = (f3 == 3'd0) ? (a == b) : (a != b);
				done = taken && (immB == 32'd0);
				pc = taken ? pc + immB : pc + `RV_PC_STEP;
			end else begin
				pc = pc + `RV_PC_STEP;
			end
		end
		if (!done) begin
			errorCount++;
			$display("reference model for %s never reached its end loop", testName);
		end
		return n;
	endfunction

	task automatic buildProgram(input int which);
		int loopTop;
		progLen = 0;
		for (int i = 0; i < 256; i++) imem[i[7:0]] = SELF_LOOP;
		case (which)
			1: begin  // Dependent ALU chain
				emitI(0, 1, 0, 5);
				emitI(0, 2, 1, -3);
				emitR(0, 0, 3, 1, 2);
				emitR(32, 0, 4, 3, 1);
				emitI(1, 5, 4, 3);
				emitI(4, 6, 5, 127);
				emitR(0, 6, 7, 6, 2);
				emitR(0, 7, 8, 7, 5);
				emitR(0, 1, 9, 1, 2);
				emitI(0, 10, 0, -100);
				emitI(5, 11, 10, 1024 + 2);  // srai
				emitI(5, 12, 10, 4);
				emitR(32, 5, 13, 10, 2);
				emitR(0, 5, 14, 10, 2);
				emitR(0, 2, 15, 10, 1);
				emitI(2, 16, 1, -1);
				emitR(0, 4, 17, 16, 10);
				emitI(7, 18, 10, 255);
				emitI(6, 19, 18, -256);
				emitR(0, 0, 20, 19, 19);
			end
			2: begin  // Loads feeding the next instruction
				emitLw(1, 0, 'h40);
				emitR(0, 0, 2, 1, 1);
				emitLw(3, 0, 'h44);
				emitSw(3, 0, 'h48);
				emitI(0, 5, 0, 'h48);
				emitLw(6, 5, 0);
				emitI(0, 7, 6, 1);
				emitSw(7, 5, 4);
				emitLw(8, 5, 4);
				emitR(32, 0, 9, 8, 1);
				emitLw(10, 0, 'h50);
				emitR(0, 4, 11, 2, 10);
			end
			3: begin  // Branches on fresh operands
				emitI(0, 1, 0, 0);
				emitI(0, 2, 0, 5);
				loopTop = here();
				emitSw(1, 0, 'h80);
				emitI(0, 1, 1, 1);
				emitBranch(1, 1, 2, loopTop - here());
				emitI(0, 3, 0, 7);
				emitI(0, 4, 0, 7);
				emitBranch(0, 3, 4, 8);
				emitSw(3, 0, 'hC0);  // Flushed and must never show up
				emitI(0, 5, 0, 9);
				emitBranch(0, 5, 3, 8);
				emitSw(5, 0, 'hC4);
				emitBranch(1, 3, 4, 8);
				emitSw(4, 0, 'hC8);
				emitBranch(1, 5, 4, 12);
				emitSw(5, 0, 'hCC);
				emitSw(5, 0, 'hD0);
				emitLw(7, 0, 'hC4);
				emitBranch(0, 7, 5, 8);  // Operand straight from a load
				emitI(0, 6, 0, 2);
				emitI(0, 8, 6, 3);
				emitI(0, 9, 0, 3);
				loopTop = here();
				emitI(0, 9, 9, -1);
				emitBranch(0, 9, 0, 8);
				emitBranch(0, 0, 0, loopTop - here());
				emitR(32, 0, 10, 8, 9);
			end
			default: begin  // Writes aimed at x0
				emitI(0, 0, 0, 55);
				emitR(0, 0, 1, 0, 0);
				emitI(0, 2, 0, 77);
				emitR(0, 0, 0, 2, 2);
				emitR(0, 6, 3, 0, 2);
				emitLw(0, 0, 'h40);
				emitR(0, 0, 4, 0, 0);
				emitSw(0, 0, 'h60);
			end
		endcase
		storeAllRegs();
	endtask

	task automatic runProgram(input string name, input int which, input bit stalls);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		testName = name;
		randomStalls = stalls;
		buildProgram(which);
		expCount = runReference();
		// Ten reset edges with the last check in the first cycle out of reset
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			if (i == 9) rst_n = 1'b1;
			@(negedge clk);
			checkValue({name, " idle dRead"}, 32'd0, {31'b0, dRead});
			checkValue({name, " idle dWrite"}, 32'd0, {31'b0, dWrite});
			checkValue({name, " idle iAddr"}, 32'd0, {2'b00, iAddr});
		end
		while (seen < expCount) @(posedge clk);
		repeat (DRAIN_CYCLES) @(posedge clk);
		checkValue({name, " store count"}, expCount, seen);
	endtask

	// ============================================================
	// Processes
	// ============================================================
	initial begin
		logic stallOn;
		iStall = 1'b0;
		dStall = 1'b0;
		rngState = 32'd22;
		forever begin
			@(posedge clk);
			stallOn = randomStalls && rst_n;  // Sampled on the edge before the testbench drives
			#1;
			if (stallOn) begin
				rngState = xorshift32(rngState);
				iStall = (rngState[1:0] == 2'b00);
				dStall = (rngState[5:4] == 2'b00);
			end else begin
				iStall = 1'b0;
				dStall = 1'b0;
			end
		end
	end

	// Data memory plus store monitor
	initial begin
		seen = 0;
		for (int i = 0; i < 256; i++) dmem[i[7:0]] = fillWord(i[7:0]);
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				for (int i = 0; i < 256; i++) dmem[i[7:0]] = fillWord(i[7:0]);
				seen = 0;
			end else if (dWrite && !dStall) begin
				dmem[dAddr[7:0]] = dWdata;
				// A fetch stall holds the same store so it counts once as it leaves
				if (!iStall) begin
					if (seen < expCount) begin
						checkValue({testName, " store addr"}, expAddr[seen[7:0]], {2'b00, dAddr});
						checkValue({testName, " store data"}, expData[seen[7:0]], dWdata);
					end else begin
						errorCount++;
						$display("unexpected store in %s to word %h with data %h",
							testName, dAddr, dWdata);
					end
					seen++;
				end
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= MAX_CYCLES) begin
				$display("timeout after %0d cycles in %s, stores seen %0d of %0d",
					cycles, testName, seen, expCount);
				$display("=== FAIL ===");
				$finish;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		errorCount = 0;
		checkCount = 0;
		expCount = 0;
		randomStalls = 1'b0;
		testName = "startup";
		for (int i = 0; i < 256; i++) imem[i[7:0]] = SELF_LOOP;
		runProgram("alu chain", 1, 1'b0);
		runProgram("load use", 2, 1'b0);
		runProgram("branches", 3, 1'b0);
		runProgram("x0 writes", 4, 1'b0);
		runProgram("alu chain stalled", 1, 1'b1);
		runProgram("load use stalled", 2, 1'b1);
		runProgram("branches stalled", 3, 1'b1);
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/rvAlu.sv
hdl/rvDecoder.sv
hdl/rvRegFile.sv
hdl/rvHazardUnit.sv
hdl/rvCore.sv
sim/tb_rvCore.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run, success only if the pass line is printed
cd "$(dirname "$0")" \
	&& verilator --binary --assert -j 0 --top-module tb_rvCore -f sources.f \
	&& ./obj_dir/Vtb_rvCore | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
